// ==== src.f ====
motor_pkg.sv
regmap_pkg.sv
reg_bus_decode.sv
drive_channel.sv
rotation_channel.sv
rotation_config.sv
reg_read_mux.sv
motor_reg_top.sv
tb_motor_reg.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the motor register testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_motor_reg \
    -Mdir obj_dir -o sim_motor_reg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_motor_reg > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

// ==== tb_motor_reg.sv ====
////////////////////
// Motor register block testbench
// Table-driven bus writes and reads with side checks on the outputs
////////////////////
`default_nettype none

module tb_motor_reg;
    import motor_pkg::*;
    import regmap_pkg::*;

    typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} bus_op_e;

    // Output checks tied to a table row
    typedef enum logic [3:0] {
        SC_NONE, SC_RESET, SC_DRIVE_GRP, SC_ROT_GRP, SC_ALL_GRP, SC_SINGLE,
        SC_TARGET, SC_UPDATE, SC_ABORT, SC_PULSE_LO, SC_MOVE_ANGLE, SC_SETTINGS
    } side_check_e;

    typedef struct packed {
        bus_op_e     op;
        logic [5:0]  addr;
        logic [7:0]  data;
        logic [7:0]  exp_data;  // Read rows only
        side_check_e side;
    } table_row_t;

    localparam logic [7:0] DRV_GRP_DATA = 8'hA5;
    localparam logic [7:0] ROT_GRP_DATA = 8'h5C;
    localparam logic [7:0] ALL_GRP_DATA = 8'h3B;
    localparam logic [7:0] DRV2_DATA    = 8'hC7;  // Drive channel 2 alone
    localparam logic [7:0] ROT1_DATA    = 8'h2E;  // Rotation channel 1 alone
    localparam logic [7:0] ROT2_DATA    = 8'h49;
    localparam logic [7:0] TARGET2_DATA = 8'hD2;
    localparam logic [7:0] GEN_DATA     = 8'h6A;  // Bit 1 set
    localparam logic [7:0] OFFSET_DATA  = 8'h17;
    localparam logic [7:0] CRUISE_DATA  = 8'h8C;
    localparam logic [7:0] DELAY_DATA   = 8'hE1;

    logic                 clock;
    logic                 rst;
    reg_req_t             req;
    logic [7:0]           rd_data;
    motor_status_t [3:0]  drive_status;
    drive_ctrl_t   [3:0]  drive_ctrl;
    motor_status_t [3:0]  rot_status;
    angle_t        [3:0]  current_angle;
    logic          [3:0]  angle_done;
    rot_ctrl_t     [3:0]  rot_ctrl;
    angle_t        [3:0]  target_angle;
    logic          [3:0]  update_angle;
    logic          [3:0]  abort_angle;
    logic                 enable_stall_chk;
    logic [7:0]           profile_offset;
    logic [7:0]           cruise_power;
    logic [7:0]           delay_target;
    logic [15:0][7:0]     pwm_profile;

    table_row_t       rows[$];
    logic             table_ready;
    logic [15:0][7:0] profile_exp;  // Written profile, entry 0 lowest
    angle_t           snap_exp;     // Angle at the snapshot command

    motor_reg_top motor_reg_top_inst (
        .clock(clock), .rst(rst), .req(req), .rd_data(rd_data),
        .drive_status(drive_status), .drive_ctrl(drive_ctrl),
        .rot_status(rot_status), .current_angle(current_angle),
        .angle_done(angle_done), .rot_ctrl(rot_ctrl), .target_angle(target_angle),
        .update_angle(update_angle), .abort_angle(abort_angle),
        .enable_stall_chk(enable_stall_chk), .profile_offset(profile_offset),
        .cruise_power(cruise_power), .delay_target(delay_target),
        .pwm_profile(pwm_profile)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_row(input bus_op_e op, input logic [5:0] addr, input logic [7:0] data,
                           input logic [7:0] exp_data, input side_check_e side);
        table_row_t row;
        row = '{op, addr, data, exp_data, side};
        rows.push_back(row);
    endtask

    task automatic add_write(input logic [5:0] addr, input logic [7:0] data,
                             input side_check_e side);
        add_row(OP_WRITE, addr, data, 8'h00, side);
    endtask

    task automatic expect_read(input logic [5:0] addr, input logic [7:0] exp_data);
        add_row(OP_READ, addr, 8'h00, exp_data, SC_NONE);
    endtask

    task automatic check_ctrl_bytes(input logic [3:0][7:0] drv_exp,
                                    input logic [3:0][7:0] rot_exp);
        for (int i = 0; i < 4; i++) begin
            check_eq($sformatf("drive_ctrl[%0d]", i), 32'(drive_ctrl[i]), 32'(drv_exp[i]));
            check_eq($sformatf("rot_ctrl[%0d]", i), 32'(rot_ctrl[i]), 32'(rot_exp[i]));
        end
    endtask

    // Output checks after the row's clock edge, driven on the falling edge
    task automatic check_side(input side_check_e side);
        case (side)
            SC_RESET: begin
                check_ctrl_bytes('0, '0);
                for (int i = 0; i < 4; i++) begin
                    check_eq($sformatf("target_angle[%0d]", i), 32'(target_angle[i]), 0);
                end
                check_eq("update_angle", 32'(update_angle), 0);
                check_eq("abort_angle", 32'(abort_angle), 0);
                check_eq("enable_stall_chk", 32'(enable_stall_chk), 0);
                check_eq("profile_offset", 32'(profile_offset), 0);
                check_eq("cruise_power", 32'(cruise_power), 0);
                check_eq("delay_target", 32'(delay_target), 0);
                for (int k = 0; k < 16; k++) begin
                    check_eq($sformatf("pwm_profile[%0d]", k), 32'(pwm_profile[k]), 0);
                end
            end
            SC_DRIVE_GRP: check_ctrl_bytes({4{DRV_GRP_DATA}}, '0);
            SC_ROT_GRP:   check_ctrl_bytes({4{DRV_GRP_DATA}}, {4{ROT_GRP_DATA}});
            SC_ALL_GRP:   check_ctrl_bytes({4{ALL_GRP_DATA}}, {4{ALL_GRP_DATA}});
            SC_SINGLE: check_ctrl_bytes({ALL_GRP_DATA, DRV2_DATA, ALL_GRP_DATA, ALL_GRP_DATA},
                                        {ALL_GRP_DATA, ALL_GRP_DATA, ROT1_DATA, ALL_GRP_DATA});
            SC_TARGET: begin
                // Control nibble on top of the target byte
                check_eq("target_angle[2]", 32'(target_angle[2]),
                         32'({ROT2_DATA[3:0], TARGET2_DATA}));
                check_eq("target_angle[1]", 32'(target_angle[1]), 32'({ROT1_DATA[3:0], 8'h00}));
                check_eq("target_angle[0]", 32'(target_angle[0]),
                         32'({ALL_GRP_DATA[3:0], 8'h00}));
            end
            SC_UPDATE: begin
                check_eq("update_angle", 32'(update_angle), 32'h4);
                check_eq("abort_angle", 32'(abort_angle), 0);
            end
            SC_ABORT: begin
                check_eq("update_angle", 32'(update_angle), 0);
                check_eq("abort_angle", 32'(abort_angle), 32'h4);
            end
            SC_PULSE_LO, SC_MOVE_ANGLE: begin
                check_eq("update_angle", 32'(update_angle), 0);
                check_eq("abort_angle", 32'(abort_angle), 0);
                if (side == SC_MOVE_ANGLE) current_angle[2] = ~current_angle[2];
            end
            SC_SETTINGS: begin
                check_eq("enable_stall_chk", 32'(enable_stall_chk), 32'(GEN_DATA[1]));
                check_eq("profile_offset", 32'(profile_offset), 32'(OFFSET_DATA));
                check_eq("cruise_power", 32'(cruise_power), 32'(CRUISE_DATA));
                check_eq("delay_target", 32'(delay_target), 32'(DELAY_DATA));
                for (int k = 0; k < 16; k++) begin
                    check_eq($sformatf("pwm_profile[%0d]", k), 32'(pwm_profile[k]),
                             32'(profile_exp[k]));
                end
            end
            default: ;
        endcase
    endtask

    task automatic build_table();
        add_row(OP_IDLE, 6'h00, 8'h00, 8'h00, SC_RESET);
        for (int i = 0; i < 4; i++) begin
            expect_read(6'(4 + 2 * i), 8'h00);   // Drive control
            expect_read(6'(12 + 5 * i), 8'h00);  // Rotation control
            expect_read(6'(14 + 5 * i), 8'h00);  // Target low byte
        end
        expect_read(6'h20, 8'h00);
        expect_read(6'h21, 8'h00);
        expect_read(6'h22, 8'h00);
        expect_read(6'h3D, 8'h00);
        // Broadcast groups, then single channels
        add_write(6'h03, DRV_GRP_DATA, SC_DRIVE_GRP);
        add_write(6'h02, ROT_GRP_DATA, SC_ROT_GRP);
        add_write(6'h01, ALL_GRP_DATA, SC_ALL_GRP);
        add_write(6'h08, DRV2_DATA, SC_NONE);
        add_write(6'h11, ROT1_DATA, SC_SINGLE);
        for (int i = 0; i < 4; i++) begin
            expect_read(6'(4 + 2 * i), (i == 2) ? DRV2_DATA : ALL_GRP_DATA);
            expect_read(6'(12 + 5 * i), (i == 1) ? ROT1_DATA : ALL_GRP_DATA);
        end
        for (int i = 0; i < 4; i++) begin
            expect_read(6'(5 + 2 * i), drive_status[i]);
            expect_read(6'(13 + 5 * i), rot_status[i]);
        end
        // Rotation channel 2 at 0x16
        add_write(6'h16, ROT2_DATA, SC_NONE);
        add_write(6'h18, TARGET2_DATA, SC_TARGET);
        add_write(6'h1A, 8'h60, SC_UPDATE);  // Snapshot and update
        add_row(OP_IDLE, 6'h00, 8'h00, 8'h00, SC_PULSE_LO);
        add_write(6'h1A, 8'h10, SC_ABORT);
        add_row(OP_IDLE, 6'h00, 8'h00, 8'h00, SC_MOVE_ANGLE);
        add_row(OP_IDLE, 6'h00, 8'h00, 8'h00, SC_NONE);
        expect_read(6'h16, ROT2_DATA);
        expect_read(6'h18, TARGET2_DATA);
        expect_read(6'h19, snap_exp[7:0]);
        expect_read(6'h1A, {angle_done[2], 3'b000, snap_exp[11:8]});
        // Shared settings and profile table
        for (int k = 0; k < 16; k++) begin
            profile_exp[k] = 8'(49 + 13 * k);
            add_write(6'(45 + k), profile_exp[k], SC_NONE);
        end
        add_write(6'h20, GEN_DATA, SC_NONE);
        add_write(6'h21, OFFSET_DATA, SC_NONE);
        add_write(6'h22, CRUISE_DATA, SC_NONE);
        add_write(6'h3D, DELAY_DATA, SC_SETTINGS);
        expect_read(6'h20, GEN_DATA);
        expect_read(6'h21, OFFSET_DATA);
        expect_read(6'h22, CRUISE_DATA);
        expect_read(6'h3D, DELAY_DATA);
        for (int k = 0; k < 16; k++) begin
            expect_read(6'(45 + k), profile_exp[k]);
        end
        for (int a = 6'h23; a <= 6'h2C; a++) begin
            expect_read(6'(a), 8'h00);  // Servo, debug and LED space
        end
        expect_read(6'h3E, 8'h00);
        expect_read(6'h00, 8'h00);
        expect_read(6'h01, 8'h00);
        expect_read(6'h02, 8'h00);
        expect_read(6'h03, 8'h00);
    endtask

    initial begin
        table_ready = 1'b0;
        void'($urandom(24));
        rst = 1'b1;
        req = '0;
        for (int i = 0; i < 4; i++) begin
            drive_status[i]  = 8'($urandom());
            rot_status[i]    = 8'($urandom());
            current_angle[i] = 12'($urandom());
        end
        angle_done = 4'($urandom()) | 4'b0100;  // Channel 2 reports done
        snap_exp = current_angle[2];
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        for (int r = 0; r <= rows.size(); r++) begin
            @(negedge clock);
            if (r > 0) begin
                if (rows[r-1].op == OP_READ) begin
                    check_eq($sformatf("rd_data@%0h", rows[r-1].addr), 32'(rd_data),
                             32'(rows[r-1].exp_data));
                end
                check_side(rows[r-1].side);
            end
            req = '0;
            if (r < rows.size()) begin
                req.write_en = (rows[r].op == OP_WRITE);
                req.read_en  = (rows[r].op == OP_READ);
                req.address  = rows[r].addr;
                req.wr_data  = rows[r].data;
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Four clock periods per row, reset included
    initial begin
        wait (table_ready);
        #((rows.size() + 10) * 8 * 4);
        $display("Timeout: the stimulus table did not finish in time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== motor_reg_top.sv ====
////////////////////
// Motor register block
// Host registers for the swerve drive and rotation motors
////////////////////
`default_nettype none

module motor_reg_top #(
    parameter int  NUM_DRIVE   = 4,
    parameter int  NUM_ROT     = 4,
    parameter int  PROFILE_LEN = 16
) (
    input  logic                                    clock,
    input  logic                                    rst,
    input  regmap_pkg::reg_req_t                    req,
    output logic [7:0]                              rd_data,
    input  motor_pkg::motor_status_t [NUM_DRIVE-1:0] drive_status,
    output motor_pkg::drive_ctrl_t   [NUM_DRIVE-1:0] drive_ctrl,
    input  motor_pkg::motor_status_t [NUM_ROT-1:0]   rot_status,
    input  motor_pkg::angle_t        [NUM_ROT-1:0]   current_angle,
    input  logic                     [NUM_ROT-1:0]   angle_done,
    output motor_pkg::rot_ctrl_t     [NUM_ROT-1:0]   rot_ctrl,
    output motor_pkg::angle_t        [NUM_ROT-1:0]   target_angle,
    output logic                     [NUM_ROT-1:0]   update_angle,
    output logic                     [NUM_ROT-1:0]   abort_angle,
    output logic                                    enable_stall_chk,
    output logic [7:0]                              profile_offset,
    output logic [7:0]                              cruise_power,
    output logic [7:0]                              delay_target,
    output logic [PROFILE_LEN-1:0][7:0]             pwm_profile
);
    import motor_pkg::*;
    import regmap_pkg::*;

    localparam int NUM_CFG = CFG_PROFILE + PROFILE_LEN;

    logic [NUM_DRIVE-1:0] drive_ctrl_we;
    logic [NUM_ROT-1:0]   rot_ctrl_we;
    logic [NUM_ROT-1:0]   rot_target_we;
    logic [NUM_ROT-1:0]   rot_cmd_we;
    logic [NUM_CFG-1:0]   cfg_we;

    motor_status_t [NUM_DRIVE-1:0] drive_status_q;
    logic [NUM_DRIVE-1:0][1:0][7:0] drive_bytes;  // Control, status
    logic [NUM_ROT-1:0][4:0][7:0]   rot_bytes;
    logic [NUM_CFG-1:0][7:0]        cfg_bytes;

    reg_bus_decode #(
        .NUM_DRIVE(NUM_DRIVE), .NUM_ROT(NUM_ROT), .PROFILE_LEN(PROFILE_LEN)
    ) reg_bus_decode_inst (
        .clock(clock), .rst(rst), .req(req),
        .drive_ctrl_we(drive_ctrl_we), .rot_ctrl_we(rot_ctrl_we),
        .rot_target_we(rot_target_we), .rot_cmd_we(rot_cmd_we), .cfg_we(cfg_we)
    );

    for (genvar i = 0; i < NUM_DRIVE; i++) begin : g_drive
        drive_channel drive_channel_inst (
            .clock(clock), .rst(rst), .ctrl_we(drive_ctrl_we[i]),
            .wr_data(req.wr_data), .status_in(drive_status[i]),
            .ctrl(drive_ctrl[i]), .status_q(drive_status_q[i])
        );
        assign drive_bytes[i] = {drive_status_q[i], drive_ctrl[i]};
    end

    for (genvar i = 0; i < NUM_ROT; i++) begin : g_rot
        rotation_channel rotation_channel_inst (
            .clock(clock), .rst(rst), .ctrl_we(rot_ctrl_we[i]),
            .target_we(rot_target_we[i]), .cmd_we(rot_cmd_we[i]),
            .wr_data(req.wr_data), .status_in(rot_status[i]),
            .current_angle(current_angle[i]), .angle_done(angle_done[i]),
            .ctrl(rot_ctrl[i]), .target_angle(target_angle[i]),
            .update_angle(update_angle[i]), .abort_angle(abort_angle[i]),
            .read_bytes(rot_bytes[i])
        );
    end

    rotation_config #(.PROFILE_LEN(PROFILE_LEN)) rotation_config_inst (
        .clock(clock), .rst(rst), .cfg_we(cfg_we), .wr_data(req.wr_data),
        .enable_stall_chk(enable_stall_chk), .profile_offset(profile_offset),
        .cruise_power(cruise_power), .delay_target(delay_target),
        .pwm_profile(pwm_profile), .read_bytes(cfg_bytes)
    );

    reg_read_mux #(
        .NUM_DRIVE(NUM_DRIVE), .NUM_ROT(NUM_ROT), .PROFILE_LEN(PROFILE_LEN)
    ) reg_read_mux_inst (
        .clock(clock), .rst(rst), .req(req),
        .drive_bytes(drive_bytes), .rot_bytes(rot_bytes), .cfg_bytes(cfg_bytes),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// ==== reg_read_mux.sv ====
////////////////////
// Read mux
// Picks the addressed byte and registers it
////////////////////
`default_nettype none

module reg_read_mux #(
    parameter int  NUM_DRIVE   = 4,
    parameter int  NUM_ROT     = 4,
    parameter int  PROFILE_LEN = 16,
    localparam int NUM_CFG     = regmap_pkg::CFG_PROFILE + PROFILE_LEN
) (
    input  logic                      clock,
    input  logic                      rst,
    input  regmap_pkg::reg_req_t      req,
    input  logic [NUM_DRIVE-1:0][1:0][7:0] drive_bytes,
    input  logic [NUM_ROT-1:0][4:0][7:0]   rot_bytes,
    input  logic [NUM_CFG-1:0][7:0]        cfg_bytes,
    output logic [7:0]                     rd_data
);
    import regmap_pkg::*;

    logic [7:0] rd_next;  // Zero unless some register matches

    always_comb begin
        rd_next = '0;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            for (int b = 0; b < DRIVE_STRIDE; b++) begin
                if (req.address == ADDR_W'(drive_addr(i, b))) begin
                    rd_next = drive_bytes[i][b];
                end
            end
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            for (int b = 0; b < ROT_STRIDE; b++) begin
                if (req.address == ADDR_W'(rot_addr(NUM_DRIVE, i, b))) begin
                    rd_next = rot_bytes[i][b];
                end
            end
        end
        if (req.address == ROT_GEN_CTRL)   rd_next = cfg_bytes[CFG_GEN];
        if (req.address == PROFILE_OFFSET) rd_next = cfg_bytes[CFG_OFFSET];
        if (req.address == CRUISE_POWER)   rd_next = cfg_bytes[CFG_CRUISE];
        if (req.address == DELAY_TARGET)   rd_next = cfg_bytes[CFG_DELAY];
        for (int k = 0; k < PROFILE_LEN; k++) begin
            if (req.address == ADDR_W'(PROFILE_BASE + k)) begin
                rd_next = cfg_bytes[CFG_PROFILE+k];
            end
        end
    end

    // Holds the last read until the next one
    always_ff @(posedge clock) begin
        if (rst) begin
            rd_data <= '0;
        end else if (req.read_en) begin
            rd_data <= rd_next;
        end
    end

endmodule

`default_nettype wire

// ==== rotation_config.sv ====
////////////////////
// Rotation settings
// Shared rotation controls and PWM profile table
////////////////////
`default_nettype none

module rotation_config #(
    parameter int  PROFILE_LEN = 16,
    localparam int NUM_CFG     = regmap_pkg::CFG_PROFILE + PROFILE_LEN
) (
    input  logic                        clock,
    input  logic                        rst,
    input  logic [NUM_CFG-1:0]          cfg_we,
    input  logic [7:0]                  wr_data,
    output logic                        enable_stall_chk,
    output logic [7:0]                  profile_offset,
    output logic [7:0]                  cruise_power,
    output logic [7:0]                  delay_target,
    output logic [PROFILE_LEN-1:0][7:0] pwm_profile,
    output logic [NUM_CFG-1:0][7:0]     read_bytes
);
    import regmap_pkg::*;

    logic [NUM_CFG-1:0][7:0] cfg_q;  // One byte per setting

    always_ff @(posedge clock) begin
        if (rst) begin
            cfg_q <= '0;
        end else begin
            for (int k = 0; k < NUM_CFG; k++) begin
                if (cfg_we[k]) begin
                    cfg_q[k] <= wr_data;
                end
            end
        end
    end

    // Other bits of the general byte are stored for readback only
    assign enable_stall_chk = cfg_q[CFG_GEN][STALL_CHK_BIT];
    assign profile_offset   = cfg_q[CFG_OFFSET];
    assign cruise_power     = cfg_q[CFG_CRUISE];
    assign delay_target     = cfg_q[CFG_DELAY];
    assign pwm_profile      = cfg_q[NUM_CFG-1:CFG_PROFILE];  // Entry 0 lowest

    assign read_bytes = cfg_q;

endmodule

`default_nettype wire

// ==== rotation_channel.sv ====
////////////////////
// Rotation motor channel
// Control, target angle, command pulses and angle snapshot
////////////////////
`default_nettype none

module rotation_channel (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     ctrl_we,
    input  logic                     target_we,
    input  logic                     cmd_we,
    input  logic [7:0]               wr_data,
    input  motor_pkg::motor_status_t status_in,
    input  motor_pkg::angle_t        current_angle,
    input  logic                     angle_done,
    output motor_pkg::rot_ctrl_t     ctrl,
    output motor_pkg::angle_t        target_angle,
    output logic                     update_angle,
    output logic                     abort_angle,
    output logic [4:0][7:0]          read_bytes
);
    import motor_pkg::*;
    import regmap_pkg::*;

    logic [7:0]    target_lo;  // Target angle bits 7:0
    angle_t        snap;       // Held so both halves read coherently
    motor_status_t status_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            ctrl         <= '0;
            target_lo    <= '0;
            snap         <= '0;
            update_angle <= 1'b0;
            abort_angle  <= 1'b0;
        end else begin
            if (ctrl_we) begin
                ctrl <= rot_ctrl_t'(wr_data);
            end
            if (target_we) begin
                target_lo <= wr_data;
            end
            // Single-cycle pulses, no write means no pulse
            update_angle <= cmd_we && wr_data[CMD_UPDATE_BIT];
            abort_angle  <= cmd_we && wr_data[CMD_ABORT_BIT];
            if (cmd_we && wr_data[CMD_SNAP_BIT]) begin
                snap <= current_angle;
            end
        end
    end

    always_ff @(posedge clock) begin
        status_q <= status_in;  // Sampled every cycle
    end

    // High nibble lives in the control byte
    assign target_angle = {ctrl.angle_hi, target_lo};

    assign read_bytes[ROT_OFS_CTRL]    = ctrl;
    assign read_bytes[ROT_OFS_STATUS]  = status_q;
    assign read_bytes[ROT_OFS_TARGET]  = target_lo;
    assign read_bytes[ROT_OFS_CURR_LO] = snap[7:0];
    assign read_bytes[ROT_OFS_CURR_HI] = {angle_done, 3'b000, snap[ANGLE_W-1:8]};

    // Ctrl, target and command sit at distinct addresses
    a_one_strobe: assert property (@(posedge clock) disable iff (rst)
        $onehot0({ctrl_we, target_we, cmd_we}));

endmodule

`default_nettype wire

// ==== drive_channel.sv ====
////////////////////
// Drive motor channel
// Control byte and sampled status
////////////////////
`default_nettype none

module drive_channel (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     ctrl_we,
    input  logic [7:0]               wr_data,
    input  motor_pkg::motor_status_t status_in,
    output motor_pkg::drive_ctrl_t   ctrl,
    output motor_pkg::motor_status_t status_q
);
    import motor_pkg::*;

    always_ff @(posedge clock) begin
        if (rst) begin
            ctrl <= '0;                       // Brake off, motor disabled
        end else if (ctrl_we) begin
            ctrl <= drive_ctrl_t'(wr_data);
        end
    end

    // Fault and temperature follow the motor every cycle
    always_ff @(posedge clock) begin
        status_q <= status_in;
    end

endmodule

`default_nettype wire

// ==== reg_bus_decode.sv ====
////////////////////
// Write decoder
// Bus write to per-register strobes, broadcast groups included
////////////////////
`default_nettype none

module reg_bus_decode #(
    parameter int  NUM_DRIVE   = 4,
    parameter int  NUM_ROT     = 4,
    parameter int  PROFILE_LEN = 16,
    localparam int NUM_CFG     = regmap_pkg::CFG_PROFILE + PROFILE_LEN
) (
    input  logic                 clock,
    input  logic                 rst,
    input  regmap_pkg::reg_req_t req,
    output logic [NUM_DRIVE-1:0] drive_ctrl_we,
    output logic [NUM_ROT-1:0]   rot_ctrl_we,
    output logic [NUM_ROT-1:0]   rot_target_we,
    output logic [NUM_ROT-1:0]   rot_cmd_we,
    output logic [NUM_CFG-1:0]   cfg_we
);
    import regmap_pkg::*;

    logic wr_drive_grp;  // Broadcast hits every drive
    logic wr_rot_grp;    // Broadcast hits every rotation motor

    assign wr_drive_grp = req.write_en &&
                          (req.address == BCAST_ALL || req.address == BCAST_DRIVE);
    assign wr_rot_grp   = req.write_en &&
                          (req.address == BCAST_ALL || req.address == BCAST_ROT);

    always_comb begin
        for (int i = 0; i < NUM_DRIVE; i++) begin
            drive_ctrl_we[i] = wr_drive_grp ||
                (req.write_en && req.address == ADDR_W'(drive_addr(i, 0)));
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            rot_ctrl_we[i]   = wr_rot_grp ||
                (req.write_en && req.address == ADDR_W'(rot_addr(NUM_DRIVE, i, ROT_OFS_CTRL)));
            rot_target_we[i] = req.write_en &&
                req.address == ADDR_W'(rot_addr(NUM_DRIVE, i, ROT_OFS_TARGET));
            // Commands ride on the high angle byte
            rot_cmd_we[i]    = req.write_en &&
                req.address == ADDR_W'(rot_addr(NUM_DRIVE, i, ROT_OFS_CURR_HI));
        end
        cfg_we[CFG_GEN]    = req.write_en && req.address == ROT_GEN_CTRL;
        cfg_we[CFG_OFFSET] = req.write_en && req.address == PROFILE_OFFSET;
        cfg_we[CFG_CRUISE] = req.write_en && req.address == CRUISE_POWER;
        cfg_we[CFG_DELAY]  = req.write_en && req.address == DELAY_TARGET;
        for (int k = 0; k < PROFILE_LEN; k++) begin
            cfg_we[CFG_PROFILE+k] = req.write_en && req.address == ADDR_W'(PROFILE_BASE + k);
        end
    end

    // Channel map must stop short of the settings
    if (rot_addr(NUM_DRIVE, NUM_ROT, 0) > ROT_GEN_CTRL) begin : g_map_check
        $error("Rotation channels overrun the settings block");
    end

    // An X address could fire strobes in several blocks at once
    a_addr_known: assert property (@(posedge clock) disable iff (rst)
        req.write_en |-> !$isunknown(req.address));

endmodule

`default_nettype wire

// ==== regmap_pkg.sv ====
////////////////////
// Register map
// Host bus request, address map and command bit positions
////////////////////
`default_nettype none

package regmap_pkg;

    localparam int ADDR_W = 6;
    localparam int DATA_W = 8;

    typedef struct packed {
        logic              write_en;
        logic              read_en;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] wr_data;
    } reg_req_t;

    typedef enum logic [ADDR_W-1:0] {
        BCAST_ALL      = 6'h01,  // Every motor control byte
        BCAST_ROT      = 6'h02,  // Rotation control bytes only
        BCAST_DRIVE    = 6'h03,  // Drive control bytes only
        DRIVE_BASE     = 6'h04,
        ROT_BASE       = 6'h0C,  // Where rotation starts with four drives
        ROT_GEN_CTRL   = 6'h20,
        PROFILE_OFFSET = 6'h21,
        CRUISE_POWER   = 6'h22,
        PROFILE_BASE   = 6'h2D,  // First PWM profile entry
        DELAY_TARGET   = 6'h3D
    } reg_addr_e;

    localparam int DRIVE_STRIDE = 2;  // Control then status
    localparam int ROT_STRIDE   = 5;

    // Byte offsets inside a rotation channel
    localparam int ROT_OFS_CTRL    = 0;
    localparam int ROT_OFS_STATUS  = 1;
    localparam int ROT_OFS_TARGET  = 2;
    localparam int ROT_OFS_CURR_LO = 3;
    localparam int ROT_OFS_CURR_HI = 4;  // Also the command byte on write

    localparam int CMD_ABORT_BIT  = 4;
    localparam int CMD_UPDATE_BIT = 5;
    localparam int CMD_SNAP_BIT   = 6;
    localparam int STALL_CHK_BIT  = 1;   // In ROT_GEN_CTRL

    // Setting index in the config block image
    localparam int CFG_GEN     = 0;
    localparam int CFG_OFFSET  = 1;
    localparam int CFG_CRUISE  = 2;
    localparam int CFG_DELAY   = 3;
    localparam int CFG_PROFILE = 4;  // Profile entries from here up

    function automatic int drive_addr(int ch, int ofs);
        return DRIVE_BASE + DRIVE_STRIDE * ch + ofs;
    endfunction

    // Rotation channels pack in right after the last drive channel
    function automatic int rot_addr(int num_drive, int ch, int ofs);
        return drive_addr(num_drive, 0) + ROT_STRIDE * ch + ofs;
    endfunction

endpackage

`default_nettype wire

// ==== motor_pkg.sv ====
////////////////////
// Motor-side types
// Control, status and angle formats of the drive and rotation motors
////////////////////
`default_nettype none

package motor_pkg;

    localparam int PWM_W   = 5;   // Drive PWM duty
    localparam int TEMP_W  = 6;   // ADC temperature
    localparam int ANGLE_W = 12;  // Rotation encoder

    typedef logic [ANGLE_W-1:0] angle_t;

    // Bit layout is the drive control byte
    typedef struct packed {
        logic             brake;
        logic             enable;
        logic             direction;
        logic [PWM_W-1:0] pwm;
    } drive_ctrl_t;

    typedef struct packed {
        logic               brake;
        logic               enable;
        logic               direction;
        logic               spare;     // Stored, no function
        logic [ANGLE_W-9:0] angle_hi;  // Target angle bits 11:8
    } rot_ctrl_t;

    // Status byte as the host sees it
    typedef struct packed {
        logic              fault;
        logic              startup_fail;  // Stalled at startup
        logic [TEMP_W-1:0] temp;
    } motor_status_t;

endpackage

`default_nettype wire
